//--- hw/arb_pkg.sv
package arb_pkg;

  localparam int NUM_PORTS = 4;
  localparam int PORT_W    = 2;
  localparam int DATA_W    = 16;
  localparam int LEN_W     = 4;
  localparam int TAG_W     = 12;

  // A header asks for len + 1 payload beats
  typedef struct packed {
    logic [LEN_W-1:0] len;
    logic [TAG_W-1:0] tag;
  } port_header_t;

  // The same port word is read as a header on the first granted beat
  // and as plain data on every beat after it
  typedef union packed {
    port_header_t      hdr;
    logic [DATA_W-1:0] data;
  } port_word_t;

  typedef struct packed {
    logic              valid;
    logic              is_header;
    logic [PORT_W-1:0] port;
    port_word_t        word;
  } bus_beat_t;

  typedef enum logic [1:0] {
    IDLE,
    HEADER,
    PAYLOAD
  } ctrl_state_t;

endpackage

//--- hw/rr_arbiter.sv
module rr_arbiter (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [arb_pkg::NUM_PORTS-1:0] req,
  input  logic                          advance,
  output logic [arb_pkg::NUM_PORTS-1:0] cand_grant,
  output logic                          cand_valid
);
  import arb_pkg::*;

  // Thermometer mask, set from the highest-priority position upward
  logic [NUM_PORTS-1:0] indic_r;
  logic [NUM_PORTS-1:0] indic_next;

  logic [NUM_PORTS-1:0] req_hi;
  logic [NUM_PORTS-1:0] req_lo;
  logic [NUM_PORTS-1:0] ored_hi;
  logic [NUM_PORTS-1:0] ored_lo;
  logic [NUM_PORTS-1:0] onehot_hi;
  logic [NUM_PORTS-1:0] onehot_lo;
  logic                 hi_sel;

  // Bit i is set when any bit at or below i is set
  function automatic logic [NUM_PORTS-1:0] prefix_or(input logic [NUM_PORTS-1:0] vec);
    logic [NUM_PORTS-1:0] acc;
    acc[0] = vec[0];
    for (int i = 1; i < NUM_PORTS; i++)
    begin
      acc[i] = acc[i-1] | vec[i];
    end
    return acc;
  endfunction

  // Requests inside the mask beat the ones that wrapped around below it
  assign req_hi = req & indic_r;
  assign req_lo = req & ~indic_r;

  assign ored_hi = prefix_or(req_hi);
  assign ored_lo = prefix_or(req_lo);

  // First set bit of each group
  assign onehot_hi = ored_hi & ~{ored_hi[NUM_PORTS-2:0], 1'b0};
  assign onehot_lo = ored_lo & ~{ored_lo[NUM_PORTS-2:0], 1'b0};

  assign hi_sel     = |req_hi;
  assign cand_grant = hi_sel ? onehot_hi : onehot_lo;
  assign cand_valid = |req;

  // Shifting the prefix-or of the winner leaves only the positions above it,
  // so the next search starts at the port after the one just granted
  assign indic_next = hi_sel ? {ored_hi[NUM_PORTS-2:0], 1'b0}
                             : {ored_lo[NUM_PORTS-2:0], 1'b0};

  // All ones puts port 0 first after reset
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      indic_r <= '1;
    end
    else if (advance)
    begin
      indic_r <= indic_next;
    end
  end

endmodule

//--- hw/burst_timer.sv
module burst_timer (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      load,
  input  logic [arb_pkg::LEN_W-1:0] len,
  output logic                      last_beat
);
  import arb_pkg::*;

  logic [LEN_W-1:0] count;
  logic             running;

  // Loaded with len, the timer stays running for len + 1 cycles
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      count   <= '0;
      running <= 1'b0;
    end
    else if (load)
    begin
      count   <= len;
      running <= 1'b1;
    end
    else if (running)
    begin
      if (count == '0)
      begin
        running <= 1'b0;
      end
      else
      begin
        count <= count - 1'b1;
      end
    end
  end

  assign last_beat = running && (count == '0);

endmodule

//--- hw/bus_ctrl_fsm.sv
module bus_ctrl_fsm (
  input  logic clk,
  input  logic rst_n,
  input  logic cand_valid,
  input  logic last_beat,
  output logic grant_load,
  output logic len_load,
  output logic in_header,
  output logic grant_release
);
  import arb_pkg::*;

  ctrl_state_t state;
  ctrl_state_t state_next;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state <= IDLE;
    end
    else
    begin
      state <= state_next;
    end
  end

  // One IDLE cycle for arbitration, one HEADER cycle, then payload until
  // the timer flags the last beat
  always_comb
  begin
    state_next    = state;
    grant_load    = 1'b0;
    len_load      = 1'b0;
    in_header     = 1'b0;
    grant_release = 1'b0;

    case (state)
      IDLE:
      begin
        if (cand_valid)
        begin
          grant_load = 1'b1;
          state_next = HEADER;
        end
      end

      // The granted port shows its header now, so its length is latched here
      HEADER:
      begin
        in_header  = 1'b1;
        len_load   = 1'b1;
        state_next = PAYLOAD;
      end

      PAYLOAD:
      begin
        if (last_beat)
        begin
          grant_release = 1'b1;
          state_next    = IDLE;
        end
      end

      default:
      begin
        state_next = IDLE;
      end
    endcase
  end

endmodule

//--- hw/port_mux.sv
module port_mux (
  input  logic                                            clk,
  input  logic                                            rst_n,
  input  logic                [arb_pkg::NUM_PORTS-1:0]    cand_grant,
  input  logic                                            load,
  input  logic                                            grant_release,
  input  logic                                            in_header,
  input  arb_pkg::port_word_t [arb_pkg::NUM_PORTS-1:0]    port_words,
  output logic                [arb_pkg::NUM_PORTS-1:0]    grant,
  output logic                [arb_pkg::LEN_W-1:0]        len_value,
  output arb_pkg::bus_beat_t                              bus
);
  import arb_pkg::*;

  logic [PORT_W-1:0] grant_idx;
  port_word_t        sel_word;

  // The grant is held for the whole burst
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      grant <= '0;
    end
    else if (grant_release)
    begin
      grant <= '0;
    end
    else if (load)
    begin
      grant <= cand_grant;
    end
  end

  always_comb
  begin
    grant_idx = '0;
    for (int i = 0; i < NUM_PORTS; i++)
    begin
      if (grant[i])
      begin
        grant_idx = PORT_W'(i);
      end
    end
  end

  assign sel_word = port_words[grant_idx];

  // Only meaningful while the word is a header
  assign len_value = sel_word.hdr.len;

  assign bus.valid     = |grant;
  assign bus.is_header = in_header;
  assign bus.port      = grant_idx;
  assign bus.word      = sel_word;

endmodule

//--- hw/bus_arbiter_top.sv
module bus_arbiter_top (
  input  logic                                            clk,
  input  logic                                            rst_n,
  input  logic                [arb_pkg::NUM_PORTS-1:0]    req,
  input  arb_pkg::port_word_t [arb_pkg::NUM_PORTS-1:0]    port_words,
  output logic                [arb_pkg::NUM_PORTS-1:0]    grant,
  output arb_pkg::bus_beat_t                              bus
);
  import arb_pkg::*;

  logic [NUM_PORTS-1:0] cand_grant;
  logic                 cand_valid;
  logic                 grant_load;
  logic                 len_load;
  logic                 in_header;
  logic                 grant_release;
  logic                 last_beat;
  logic [LEN_W-1:0]     len_value;

  // The grant strobe also moves the round-robin pointer past the winner
  rr_arbiter u_rr_arbiter (
    .clk        (clk),
    .rst_n      (rst_n),
    .req        (req),
    .advance    (grant_load),
    .cand_grant (cand_grant),
    .cand_valid (cand_valid)
  );

  burst_timer u_burst_timer (
    .clk       (clk),
    .rst_n     (rst_n),
    .load      (len_load),
    .len       (len_value),
    .last_beat (last_beat)
  );

  bus_ctrl_fsm u_bus_ctrl_fsm (
    .clk           (clk),
    .rst_n         (rst_n),
    .cand_valid    (cand_valid),
    .last_beat     (last_beat),
    .grant_load    (grant_load),
    .len_load      (len_load),
    .in_header     (in_header),
    .grant_release (grant_release)
  );

  port_mux u_port_mux (
    .clk           (clk),
    .rst_n         (rst_n),
    .cand_grant    (cand_grant),
    .load          (grant_load),
    .grant_release (grant_release),
    .in_header     (in_header),
    .port_words    (port_words),
    .grant         (grant),
    .len_value     (len_value),
    .bus           (bus)
  );

endmodule

//--- verif/tb_bus_arbiter.sv
module tb_bus_arbiter;
  timeunit 1ns;
  timeprecision 1ps;
  import arb_pkg::*;

  localparam int CLK_PERIOD   = 20;
  // Round-robin 8, skip 2, single 1, header decoding 2, random 40
  localparam int TOTAL_BURSTS = 53;
  // Longest burst is a header and 16 payload beats
  localparam int MAX_BEATS    = 17;
  localparam int WATCHDOG_NS  = (TOTAL_BURSTS * (MAX_BEATS + 4) + 100) * CLK_PERIOD;

  logic                       clk;
  logic                       rst_n;
  logic       [NUM_PORTS-1:0] req;
  port_word_t [NUM_PORTS-1:0] port_words;
  logic       [NUM_PORTS-1:0] grant;
  bus_beat_t                  bus;

  // Words each port still has to send with its bursts laid end to end
  port_word_t           port_q [NUM_PORTS][$];
  logic [NUM_PORTS-1:0] seen_grant;
  logic                 checking;

  // The reference model state describes the current cycle
  ctrl_state_t ref_state;
  int          ref_ptr;
  int          ref_port;
  int          ref_left;

  // Owner of every header seen on the bus and the payload beats after it
  int          grant_log [$];
  int          beat_log [$];

  bus_arbiter_top DUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .req        (req),
    .port_words (port_words),
    .grant      (grant),
    .bus        (bus)
  );

  always
  begin
    #(CLK_PERIOD / 2);
    clk = ~clk;
  end

  function automatic logic [NUM_PORTS-1:0] port_onehot(input int idx);
    logic [NUM_PORTS-1:0] vec;
    vec      = '0;
    vec[idx] = 1'b1;
    return vec;
  endfunction

  task automatic abort_run();
    $display("Verification failed");
    $fatal(1, "Stopping at the first error");
  endtask

  task automatic check_grant(input string name, input logic [NUM_PORTS-1:0] exp,
                             input logic [NUM_PORTS-1:0] act);
    if (act !== exp)
    begin
      $display("FAIL t=%0t %s expected %b got %b", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_word(input string name, input port_word_t exp, input port_word_t act);
    if (act.data !== exp.data)
    begin
      $display("FAIL t=%0t %s expected %h got %h", $time, name, exp.data, act.data);
      abort_run();
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp)
    begin
      $display("FAIL t=%0t %s expected %0d got %0d", $time, name, exp, act);
      abort_run();
    end
  endtask

  // The owner and header flag only mean something on a valid beat
  task automatic check_beat(input bus_beat_t exp, input bus_beat_t act);
    if (act.valid !== exp.valid)
    begin
      $display("FAIL t=%0t bus.valid expected %b got %b", $time, exp.valid, act.valid);
      abort_run();
    end
    else if (exp.valid)
    begin
      if (act.is_header !== exp.is_header)
      begin
        $display("FAIL t=%0t bus.is_header expected %b got %b", $time,
                 exp.is_header, act.is_header);
        abort_run();
      end
      if (act.port !== exp.port)
      begin
        $display("FAIL t=%0t bus.port expected %0d got %0d", $time, exp.port, act.port);
        abort_run();
      end
      check_word("bus.word", exp.word, act.word);
    end
  endtask

  task automatic queue_burst(input int port, input logic [LEN_W-1:0] len,
                             input logic [TAG_W-1:0] tag);
    port_word_t w;
    w.hdr.len = len;
    w.hdr.tag = tag;
    port_q[port].push_back(w);
    for (int i = 0; i <= int'(len); i++)
    begin
      w.data = DATA_W'($urandom);
      port_q[port].push_back(w);
    end
  endtask

  // Each port model consumes its head word on every edge it holds the grant
  always
  begin
    @(negedge clk);
    seen_grant = grant;
    @(posedge clk);
    #2;
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      if (seen_grant[p] && port_q[p].size() != 0)
      begin
        void'(port_q[p].pop_front());
      end
      req[p] = (port_q[p].size() != 0);
      if (port_q[p].size() != 0)
      begin
        port_words[p] = port_q[p][0];
      end
      else
      begin
        port_words[p] = '0;
      end
    end
  end

  task automatic model_step();
    bus_beat_t  exp_beat;
    port_word_t head;
    int         pick;
    exp_beat = '0;
    pick     = -1;
    if (ref_state == IDLE)
    begin
      check_grant("grant", '0, grant);
      check_beat(exp_beat, bus);
      // Search starts at the port after the last one granted
      for (int k = 0; k < NUM_PORTS; k++)
      begin
        if (pick < 0 && port_q[(ref_ptr + k) % NUM_PORTS].size() != 0)
        begin
          pick = (ref_ptr + k) % NUM_PORTS;
        end
      end
      if (pick >= 0)
      begin
        ref_port  = pick;
        ref_ptr   = (pick + 1) % NUM_PORTS;
        ref_state = HEADER;
      end
    end
    else if (port_q[ref_port].size() == 0)
    begin
      $display("Port %0d was granted at t=%0t with no word left to send", ref_port, $time);
      abort_run();
    end
    else
    begin
      head               = port_q[ref_port][0];
      exp_beat.valid     = 1'b1;
      exp_beat.is_header = (ref_state == HEADER);
      exp_beat.port      = PORT_W'(ref_port);
      exp_beat.word      = head;
      check_grant("grant", port_onehot(ref_port), grant);
      check_beat(exp_beat, bus);
      if (ref_state == HEADER)
      begin
        ref_left  = int'(head.hdr.len) + 1;
        ref_state = PAYLOAD;
      end
      else
      begin
        ref_left--;
        if (ref_left == 0)
        begin
          ref_state = IDLE;
        end
      end
    end
  endtask

  always @(negedge clk)
  begin
    if (checking)
    begin
      model_step();
    end
  end

  always @(negedge clk)
  begin
    if (checking && bus.valid)
    begin
      if (bus.is_header)
      begin
        grant_log.push_back(int'(bus.port));
        beat_log.push_back(0);
      end
      else if (beat_log.size() != 0)
      begin
        beat_log[beat_log.size() - 1] = beat_log[beat_log.size() - 1] + 1;
      end
    end
  end

  task automatic wait_idle();
    bit busy;
    busy = 1'b1;
    while (busy)
    begin
      @(negedge clk);
      busy = (ref_state != IDLE);
      for (int p = 0; p < NUM_PORTS; p++)
      begin
        if (port_q[p].size() != 0)
        begin
          busy = 1'b1;
        end
      end
    end
  endtask

  task automatic test_reset_state();
    bus_beat_t idle_beat;
    idle_beat = '0;
    repeat (3)
    begin
      @(negedge clk);
      check_grant("grant", '0, grant);
      check_beat(idle_beat, bus);
    end
  endtask

  task automatic test_round_robin_order();
    int first;
    first = grant_log.size();
    @(posedge clk);
    #1;
    for (int round = 0; round < 2; round++)
    begin
      for (int p = 0; p < NUM_PORTS; p++)
      begin
        queue_burst(p, LEN_W'($urandom_range(3, 0)), TAG_W'($urandom));
      end
    end
    wait_idle();
    check_count("bursts granted", 8, grant_log.size() - first);
    for (int i = 0; i < 8; i++)
    begin
      check_grant("grant order", port_onehot(i % NUM_PORTS), port_onehot(grant_log[first + i]));
    end
  endtask

  task automatic test_round_robin_skip();
    int first;
    first = grant_log.size();
    check_grant("last grant", port_onehot(3), port_onehot(grant_log[first - 1]));
    @(posedge clk);
    #1;
    queue_burst(3, 4'd2, 12'h333);
    queue_burst(1, 4'd1, 12'h111);
    wait_idle();
    check_grant("grant order", port_onehot(1), port_onehot(grant_log[first]));
    check_grant("grant order", port_onehot(3), port_onehot(grant_log[first + 1]));
  endtask

  task automatic run_single_burst(input int port, input logic [LEN_W-1:0] len,
                                  input logic [TAG_W-1:0] tag);
    port_word_t hdr_word;
    hdr_word.hdr.len = len;
    hdr_word.hdr.tag = tag;
    @(posedge clk);
    #1;
    queue_burst(port, len, tag);
    // The request is seen in IDLE at the next edge and the grant one edge later
    @(negedge clk);
    check_grant("grant", '0, grant);
    @(negedge clk);
    check_grant("grant", port_onehot(port), grant);
    check_word("header", hdr_word, bus.word);
    wait_idle();
    check_grant("grant", '0, grant);
    check_grant("granted port", port_onehot(port), port_onehot(grant_log[$]));
    check_count("payload beats", int'(len) + 1, beat_log[$]);
  endtask

  task automatic test_single_burst();
    run_single_burst(2, 4'd3, 12'h2b7);
  endtask

  task automatic test_header_decoding();
    run_single_burst(0, 4'd0, 12'ha5c);
    run_single_burst(3, 4'd15, 12'h3c1);
  endtask

  task automatic test_random_run();
    int first;
    int port;
    first = grant_log.size();
    for (int round = 0; round < 4; round++)
    begin
      repeat ($urandom_range(3, 0)) @(posedge clk);
      @(posedge clk);
      #1;
      for (int i = 0; i < 10; i++)
      begin
        port = int'($urandom_range(NUM_PORTS - 1, 0));
        queue_burst(port, LEN_W'($urandom_range(15, 0)), TAG_W'($urandom));
      end
    end
    wait_idle();
    check_count("random bursts", 40, grant_log.size() - first);
  endtask

  initial
  begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before the tests finished");
    $display("Verification failed");
    $fatal(1, "Timeout");
  end

  initial
  begin
    void'($urandom(32'h20c9));
    clk        = 1'b0;
    rst_n      = 1'b0;
    req        = '0;
    port_words = '0;
    checking   = 1'b0;
    ref_state  = IDLE;
    ref_ptr    = 0;
    ref_port   = 0;
    ref_left   = 0;
    repeat (4) @(posedge clk);
    #2;
    rst_n    = 1'b1;
    checking = 1'b1;

    test_reset_state();
    test_round_robin_order();
    test_round_robin_skip();
    test_single_burst();
    test_header_decoding();
    test_random_run();

    $display("Verification passed");
    $finish;
  end

endmodule

//--- files.f
hw/arb_pkg.sv
hw/rr_arbiter.sv
hw/burst_timer.sv
hw/bus_ctrl_fsm.sv
hw/port_mux.sv
hw/bus_arbiter_top.sv
verif/tb_bus_arbiter.sv

//--- Makefile
TOP  := tb_bus_arbiter
SIM  := obj_dir/V$(TOP)
SRCS := $(shell cat files.f)

.PHONY: all run clean

all: run

# The simulator's exit status carries the test result
run: $(SIM)
	./$(SIM)

$(SIM): files.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f files.f \
		--Mdir obj_dir -o V$(TOP)

clean:
	rm -rf obj_dir
